/* rtl/corr_config.svh */
// bit correlator build configuration, lane count, widths and pattern bits
`ifndef CORR_CONFIG_SVH
`define CORR_CONFIG_SVH

// parallel lanes per input beat
`define CORR_NUM_PARALLEL 4

// input sample width
`define CORR_WAVE_WIDTH 6

// partial and final sum width, sums wrap at this width
`define CORR_ADDER_WIDTH 12

// pattern count and taps per pattern
`define CORR_NUM_CORRS 2
`define CORR_LENGTH 4

// bit c*4+k is h_c[k], 1 means +1 and 0 means -1
// pattern 1 = 1011, pattern 0 = 0110 (k=3 down to k=0)
`define CORR_PATTERNS 8'b1011_0110

// slots per beat, one per (correlator, lane)
`define CORR_DEPTH (`CORR_NUM_PARALLEL * `CORR_NUM_CORRS)

`endif

/* rtl/corr_pkg.sv */
// bit correlator types shared by the control, datapath and output modules
`default_nettype none

`include "corr_config.svh"

package corr_pkg;

  // one input sample, two's complement
  typedef logic signed [`CORR_WAVE_WIDTH-1:0] sample_t;

  // partial or final sum
  typedef logic signed [`CORR_ADDER_WIDTH-1:0] acc_t;

  // slot tags
  typedef logic [$clog2(`CORR_NUM_PARALLEL)-1:0] lane_t;
  typedef logic [$clog2(`CORR_NUM_CORRS)-1:0] corr_t;

  // partial-sum memory address, {corr, lane}
  typedef logic [$clog2(`CORR_DEPTH)-1:0] slot_t;

  // input beat, flat on the port and split per lane inside
  typedef union packed {
    logic [`CORR_NUM_PARALLEL*`CORR_WAVE_WIDTH-1:0] flat;
    sample_t [`CORR_NUM_PARALLEL-1:0] lane;
  } in_word_u;

  // output beat, lane 0 in the low bits
  typedef acc_t [`CORR_NUM_PARALLEL-1:0] out_word_t;

endpackage

`default_nettype wire

/* rtl/corr_ram_blk.sv */
// partial-sum column, simple dual-port with registered read
`default_nettype none

`include "corr_config.svh"

module corr_ram_blk
  import corr_pkg::*;
(
  input  logic  clk,
  input  logic  adv,
  input  slot_t wr_addr,
  input  slot_t rd_addr,
  input  acc_t  din,
  output acc_t  dout
);

  // one entry per (correlator, lane) slot
  acc_t mem [`CORR_DEPTH];

  // both ports step with the pipeline
  // same-slot read and write never share a cycle
  always_ff @(posedge clk) begin
    if (adv) begin
      mem[wr_addr] <= din;
      dout         <= mem[rd_addr];
    end
  end

endmodule

`default_nettype wire

/* rtl/corr_ctrl.sv */
// correlator control, slot sequencing, clear sweep and input acceptance
`default_nettype none

`include "corr_config.svh"

module corr_ctrl
  import corr_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  s_tvalid,
  output logic  s_tready,
  input  logic  hold,
  output logic  adv,
  output logic  load,
  output logic  slot_go,
  output lane_t slot_lane,
  output corr_t slot_corr,
  output logic  clearing
);

  localparam slot_t LAST_SLOT = slot_t'(`CORR_DEPTH - 1);

  // slot counter, shared by the clear sweep and beat processing
  slot_t cnt;
  logic  busy;
  logic  last;

  ////////////////////////////////////////////////////////////////////////////
  // handshake and strobes
  ////////////////////////////////////////////////////////////////////////////

  // full output side freezes everything
  assign adv  = ~hold;
  assign last = (cnt == LAST_SLOT);

  // accept when idle, or overlap with the final slot of a beat
  assign s_tready = ~clearing & ~hold & (~busy | last);
  assign load     = s_tvalid & s_tready;

  assign slot_go = busy & adv;

  // correlator-major order: upper bit picks pattern, low bits pick lane
  assign {slot_corr, slot_lane} = cnt;

  ////////////////////////////////////////////////////////////////////////////
  // sequencer
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cnt      <= '0;
      busy     <= 1'b0;
      clearing <= 1'b1;
    end else if (adv) begin
      if (clearing) begin
        // one slot zeroed per cycle
        cnt <= cnt + 1'b1;
        if (last) begin
          clearing <= 1'b0;
        end
      end else if (busy) begin
        cnt <= cnt + 1'b1;
        // counter wraps to 0, stay busy if the next beat came in
        if (last) begin
          busy <= load;
        end
      end else if (load) begin
        busy <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/corr_tap_chain.sv */
// correlator datapath, per-slot sample select, signed taps and sum memories
`default_nettype none

`include "corr_config.svh"

module corr_tap_chain
  import corr_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     adv,
  input  logic     load,
  input  logic     clearing,
  input  logic     slot_go,
  input  lane_t    slot_lane,
  input  corr_t    slot_corr,
  input  in_word_u s_tdata,
  output logic     res_strobe,
  output acc_t     res_sum,
  output lane_t    res_lane,
  output corr_t    res_corr
);

  localparam int TAPS = `CORR_LENGTH;
  localparam logic [`CORR_NUM_CORRS*TAPS-1:0] PATS = `CORR_PATTERNS;

  in_word_u        in_q;
  sample_t         smp;
  acc_t            smp_ext;
  logic [TAPS-1:0] pat;
  acc_t            term0 [TAPS];
  acc_t            term1 [TAPS];
  acc_t            sum2  [TAPS];
  acc_t            ram_dout [TAPS-1];
  acc_t            wr_din   [TAPS-1];
  logic            v1;
  logic            v2;
  lane_t           lane1;
  lane_t           lane2;
  corr_t           corr1;
  corr_t           corr2;
  slot_t           rd_addr;
  slot_t           wr_addr;

  // beat held for all 8 slots
  always_ff @(posedge clk) begin
    if (load) begin
      in_q <= s_tdata;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stage 0, lane select and sign flip per tap
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    smp     = in_q.lane[slot_lane];
    smp_ext = smp;
    pat     = PATS[slot_corr*TAPS +: TAPS];
    // tap n multiplies by h[3-n]
    for (int n = 0; n < TAPS; n++) begin
      term0[n] = pat[TAPS-1-n] ? smp_ext : -smp_ext;
    end
  end

  assign rd_addr = {slot_corr, slot_lane};

  // stage 1 and 2 tags
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      v1    <= 1'b0;
      v2    <= 1'b0;
      lane1 <= '0;
      corr1 <= '0;
      lane2 <= '0;
      corr2 <= '0;
    end else if (adv) begin
      v1    <= slot_go;
      lane1 <= slot_lane;
      corr1 <= slot_corr;
      v2    <= v1;
      // stage 2 keeps its slot across bubbles, rewrite stays harmless
      if (v1) begin
        lane2 <= lane1;
        corr2 <= corr1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (adv) begin
      term1 <= term0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stage 2, adders and memory columns
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (adv) begin
      if (clearing) begin
        for (int n = 0; n < TAPS; n++) begin
          sum2[n] <= '0;
        end
      end else if (v1) begin
        // first tap has no predecessor
        sum2[0] <= term1[0];
        for (int n = 1; n < TAPS; n++) begin
          sum2[n] <= term1[n] + ram_dout[n-1];
        end
      end
    end
  end

  // sweep address comes straight from the sequencer
  assign wr_addr = clearing ? {slot_corr, slot_lane} : {corr2, lane2};

  for (genvar n = 0; n < TAPS - 1; n++) begin : g_col
    assign wr_din[n] = clearing ? acc_t'(0) : sum2[n];

    corr_ram_blk u_ram (
      .clk     (clk),
      .adv     (adv),
      .wr_addr (wr_addr),
      .rd_addr (rd_addr),
      .din     (wr_din[n]),
      .dout    (ram_dout[n])
    );
  end

  assign res_strobe = v2;
  assign res_sum    = sum2[TAPS-1];
  assign res_lane   = lane2;
  assign res_corr   = corr2;

endmodule

`default_nettype wire

/* rtl/corr_out_stage.sv */
// correlator output, lane gather into a word and a two-entry valid/ready buffer
`default_nettype none

`include "corr_config.svh"

module corr_out_stage
  import corr_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      adv,
  input  logic      res_strobe,
  input  acc_t      res_sum,
  input  lane_t     res_lane,
  input  corr_t     res_corr,
  output logic      hold,
  output logic      m_tvalid,
  input  logic      m_tready,
  output out_word_t m_tdata,
  output corr_t     m_tdest
);

  localparam lane_t LAST_LANE = lane_t'(`CORR_NUM_PARALLEL - 1);

  out_word_t stg_data;
  corr_t     stg_dest;
  logic      stg_valid;
  logic      take;
  logic      last_lane;
  logic      move;

  assign take      = adv & res_strobe;
  assign last_lane = (res_lane == LAST_LANE);

  // staging word drops into an empty or draining output register
  assign move = stg_valid & (~m_tvalid | m_tready);

  // both entries occupied
  assign hold = stg_valid & m_tvalid;

  ////////////////////////////////////////////////////////////////////////////
  // staging word
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (take) begin
      stg_data[res_lane] <= res_sum;
      stg_dest           <= res_corr;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      stg_valid <= 1'b0;
    end else if (take & last_lane) begin
      stg_valid <= 1'b1;
    end else if (move) begin
      stg_valid <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // output register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      m_tvalid <= 1'b0;
    end else if (~m_tvalid | m_tready) begin
      m_tvalid <= stg_valid;
    end
  end

  // payload stays put while stalled
  always_ff @(posedge clk) begin
    if (move) begin
      m_tdata <= stg_data;
      m_tdest <= stg_dest;
    end
  end

endmodule

`default_nettype wire

/* rtl/bit_corr_top.sv */
// streaming bit correlator top, control plus datapath and output stage
`default_nettype none

`include "corr_config.svh"

module bit_corr_top
  import corr_pkg::*;
(
  input  logic                                             clk,
  input  logic                                             rst_n,
  input  logic                                             s_tvalid,
  output logic                                             s_tready,
  input  logic [`CORR_NUM_PARALLEL*`CORR_WAVE_WIDTH-1:0]   s_tdata,
  output logic                                             m_tvalid,
  input  logic                                             m_tready,
  output logic [`CORR_NUM_PARALLEL*`CORR_ADDER_WIDTH-1:0]  m_tdata,
  output corr_t                                            m_tdest
);

  in_word_u s_word;
  logic     hold;
  logic     adv;
  logic     load;
  logic     slot_go;
  lane_t    slot_lane;
  corr_t    slot_corr;
  logic     clearing;
  logic     res_strobe;
  acc_t     res_sum;
  lane_t    res_lane;
  corr_t    res_corr;

  // port carries the flat view
  assign s_word.flat = s_tdata;

  corr_ctrl u_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .s_tvalid  (s_tvalid),
    .s_tready  (s_tready),
    .hold      (hold),
    .adv       (adv),
    .load      (load),
    .slot_go   (slot_go),
    .slot_lane (slot_lane),
    .slot_corr (slot_corr),
    .clearing  (clearing)
  );

  corr_tap_chain u_chain (
    .clk        (clk),
    .rst_n      (rst_n),
    .adv        (adv),
    .load       (load),
    .clearing   (clearing),
    .slot_go    (slot_go),
    .slot_lane  (slot_lane),
    .slot_corr  (slot_corr),
    .s_tdata    (s_word),
    .res_strobe (res_strobe),
    .res_sum    (res_sum),
    .res_lane   (res_lane),
    .res_corr   (res_corr)
  );

  corr_out_stage u_out (
    .clk        (clk),
    .rst_n      (rst_n),
    .adv        (adv),
    .res_strobe (res_strobe),
    .res_sum    (res_sum),
    .res_lane   (res_lane),
    .res_corr   (res_corr),
    .hold       (hold),
    .m_tvalid   (m_tvalid),
    .m_tready   (m_tready),
    .m_tdata    (m_tdata),
    .m_tdest    (m_tdest)
  );

endmodule

`default_nettype wire

/* test/corr_checker.sv */
// bit correlator checker, lane history model, expected words and output compare
`default_nettype none

`include "corr_config.svh"

module corr_checker (
  input  logic                                            clk,
  input  logic                                            rst_n,
  input  logic                                            s_tvalid,
  input  logic                                            s_tready,
  input  logic [`CORR_NUM_PARALLEL*`CORR_WAVE_WIDTH-1:0]  s_tdata,
  input  logic                                            m_tvalid,
  input  logic                                            m_tready,
  input  logic [`CORR_NUM_PARALLEL*`CORR_ADDER_WIDTH-1:0] m_tdata,
  input  logic [$clog2(`CORR_NUM_CORRS)-1:0]              m_tdest,
  input  logic                                            test_done,
  input  logic                                            all_done,
  input  int                                              test_num,
  input  int                                              tb_errs,
  output int                                              pending,
  output int                                              total_errors
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NP  = `CORR_NUM_PARALLEL;
  localparam int SW  = `CORR_WAVE_WIDTH;
  localparam int AW  = `CORR_ADDER_WIDTH;
  localparam int NC  = `CORR_NUM_CORRS;
  localparam int LEN = `CORR_LENGTH;
  localparam int DW  = $clog2(`CORR_NUM_CORRS);
  localparam logic [NC*LEN-1:0] PATS = `CORR_PATTERNS;

  // hist[p][k] is lane p, k beats back
  int              hist [NP][LEN];
  logic [NP*AW-1:0] exp_data [$];
  logic [DW-1:0]    exp_dest [$];
  logic [NP*AW-1:0] held_data;
  logic [DW-1:0]    held_dest;
  logic             stalled = 1'b0;
  int               rst_cycles = 0;
  int               err_cnt = 0;
  int               words = 0;
  int               tests_run = 0;
  int               err_base = 0;
  int               tb_base = 0;
  int               words_base = 0;

  // bit 1 adds the sample, bit 0 subtracts it
  function automatic logic [NP*AW-1:0] expected_word(input int c);
    logic [NP*AW-1:0] w;
    int acc;
    w = '0;
    for (int p = 0; p < NP; p++) begin
      acc = 0;
      for (int k = 0; k < LEN; k++) begin
        if (PATS[c*LEN+k]) begin
          acc += hist[p][k];
        end else begin
          acc -= hist[p][k];
        end
      end
      // wrap to the accumulator width
      w[p*AW +: AW] = acc[AW-1:0];
    end
    return w;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // compare process
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    logic [NP*AW-1:0] ed;
    logic [DW-1:0]    edst;
    if (!rst_n) begin
      // outputs are known only from the second reset edge on
      if (rst_cycles > 0 && (s_tready !== 1'b0 || m_tvalid !== 1'b0)) begin
        $display("s_tready or m_tvalid was high during reset");
        err_cnt++;
      end
      rst_cycles++;
      for (int p = 0; p < NP; p++) begin
        for (int k = 0; k < LEN; k++) hist[p][k] = 0;
      end
      exp_data.delete();
      exp_dest.delete();
      stalled = 1'b0;
    end else begin
      rst_cycles = 0;
      if (stalled &&
          (m_tvalid !== 1'b1 || m_tdata !== held_data || m_tdest !== held_dest)) begin
        $display("output word changed or was withdrawn while m_tready was low");
        err_cnt++;
      end
      // input transfer, shift history and queue one word per correlator
      if (s_tvalid && s_tready) begin
        for (int p = 0; p < NP; p++) begin
          for (int k = LEN - 1; k > 0; k--) hist[p][k] = hist[p][k-1];
          hist[p][0] = int'($signed(s_tdata[p*SW +: SW]));
        end
        for (int c = 0; c < NC; c++) begin
          exp_data.push_back(expected_word(c));
          exp_dest.push_back(DW'(c));
        end
      end
      if (m_tvalid && m_tready) begin
        if (exp_data.size() == 0) begin
          $display("output transfer arrived with no expected word queued");
          err_cnt++;
        end else begin
          ed   = exp_data.pop_front();
          edst = exp_dest.pop_front();
          if (m_tdata !== ed) begin
            $display("Mismatch m_tdata: expected %h, got %h", ed, m_tdata);
            err_cnt++;
          end
          if (m_tdest !== edst) begin
            $display("Mismatch m_tdest: expected %h, got %h", edst, m_tdest);
            err_cnt++;
          end
          words++;
        end
      end
      stalled   = m_tvalid && !m_tready;
      held_data = m_tdata;
      held_dest = m_tdest;
    end
    pending      = exp_data.size();
    total_errors = err_cnt + tb_errs;

    ////////////////////////////////////////////////////////////////////////////
    // reporting
    ////////////////////////////////////////////////////////////////////////////

    if (test_done) begin
      $display("test %0d %s: %0d words checked, %0d errors", test_num,
               ((err_cnt - err_base + tb_errs - tb_base) == 0) ? "ok" : "failed",
               words - words_base, err_cnt - err_base + tb_errs - tb_base);
      tests_run++;
      err_base   = err_cnt;
      tb_base    = tb_errs;
      words_base = words;
    end
    if (all_done) begin
      $display("%0d tests run, %0d words checked, %0d errors",
               tests_run, words, err_cnt + tb_errs);
    end
  end

endmodule

`default_nettype wire

/* test/tb_bit_corr.sv */
// bit correlator testbench, clock, reset, stimulus per test and watchdog
`default_nettype none

`include "corr_config.svh"

module tb_bit_corr
  import corr_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int RESET_CYCLES  = 10;
  localparam int IDLE_CYCLES   = 20;
  localparam int IMPULSE_BEATS = 5;
  localparam int RANDOM_BEATS  = 40;
  localparam int EXTREME_BEATS = 8;
  localparam int NUM_TESTS     = 6;
  localparam int TOTAL_BEATS   = IMPULSE_BEATS + 3 * RANDOM_BEATS + EXTREME_BEATS;
  // per beat budget of 4 slot passes, plus reset and sweep per test
  localparam int WATCHDOG_CYCLES = TOTAL_BEATS * `CORR_DEPTH * 4
                                 + NUM_TESTS * (RESET_CYCLES + 2 * `CORR_DEPTH)
                                 + IDLE_CYCLES;

  logic                                            clk;
  logic                                            rst_n;
  logic                                            s_tvalid;
  logic                                            s_tready;
  logic [`CORR_NUM_PARALLEL*`CORR_WAVE_WIDTH-1:0]  s_tdata;
  logic                                            m_tvalid;
  logic                                            m_tready;
  logic [`CORR_NUM_PARALLEL*`CORR_ADDER_WIDTH-1:0] m_tdata;
  corr_t                                           m_tdest;

  // test sequencing towards the checker
  logic   test_done;
  logic   all_done;
  int     test_num;
  int     tb_errs;
  int     pending;
  int     total_errors;
  logic   rdy_random;
  integer seed;

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  bit_corr_top UUT (
    .clk      (clk),
    .rst_n    (rst_n),
    .s_tvalid (s_tvalid),
    .s_tready (s_tready),
    .s_tdata  (s_tdata),
    .m_tvalid (m_tvalid),
    .m_tready (m_tready),
    .m_tdata  (m_tdata),
    .m_tdest  (m_tdest)
  );

  corr_checker u_check (
    .clk          (clk),
    .rst_n        (rst_n),
    .s_tvalid     (s_tvalid),
    .s_tready     (s_tready),
    .s_tdata      (s_tdata),
    .m_tvalid     (m_tvalid),
    .m_tready     (m_tready),
    .m_tdata      (m_tdata),
    .m_tdest      (m_tdest),
    .test_done    (test_done),
    .all_done     (all_done),
    .test_num     (test_num),
    .tb_errs      (tb_errs),
    .pending      (pending),
    .total_errors (total_errors)
  );

  ////////////////////////////////////////////////////////////////////////////
  // cycle stepping and beat building
  ////////////////////////////////////////////////////////////////////////////

  // everything moves 1 ns after the edge, m_tready too
  task automatic next_cycle();
    @(posedge clk);
    #1;
    if (rdy_random) begin
      m_tready = ($random(seed) & 1) != 0;
    end else begin
      m_tready = 1'b1;
    end
  endtask

  function automatic logic [`CORR_NUM_PARALLEL*`CORR_WAVE_WIDTH-1:0] const_word(input int v);
    in_word_u w;
    for (int p = 0; p < `CORR_NUM_PARALLEL; p++) begin
      w.lane[p] = sample_t'(v);
    end
    return w.flat;
  endfunction

  function automatic logic [`CORR_NUM_PARALLEL*`CORR_WAVE_WIDTH-1:0] random_word();
    in_word_u w;
    for (int p = 0; p < `CORR_NUM_PARALLEL; p++) begin
      w.lane[p] = sample_t'($random(seed));
    end
    return w.flat;
  endfunction

  // each lane gets either end of the sample range
  function automatic logic [`CORR_NUM_PARALLEL*`CORR_WAVE_WIDTH-1:0] extreme_word();
    in_word_u w;
    for (int p = 0; p < `CORR_NUM_PARALLEL; p++) begin
      w.lane[p] = ($random(seed) & 1) ? sample_t'(31) : sample_t'(-32);
    end
    return w.flat;
  endfunction

  task automatic apply_reset();
    rst_n    = 1'b0;
    s_tvalid = 1'b0;
    repeat (RESET_CYCLES) next_cycle();
    rst_n = 1'b1;
  endtask

  // s_tready only moves on edges, so sampling here is safe
  task automatic send_beat(input logic [`CORR_NUM_PARALLEL*`CORR_WAVE_WIDTH-1:0] data);
    logic rdy;
    s_tvalid = 1'b1;
    s_tdata  = data;
    do begin
      rdy = s_tready;
      next_cycle();
    end while (!rdy);
    s_tvalid = 1'b0;
  endtask

  // sweep zeroes one slot per cycle, ready follows right after
  task automatic wait_ready_after_sweep();
    int n;
    n = 0;
    while (!s_tready && n < `CORR_DEPTH + 4) begin
      next_cycle();
      n++;
    end
    if (!s_tready) begin
      $display("s_tready did not rise after the clear sweep");
      tb_errs++;
    end else if (n != `CORR_DEPTH) begin
      $display("s_tready rose %0d cycles after reset, the clear sweep takes %0d cycles",
               n, `CORR_DEPTH);
      tb_errs++;
    end
  endtask

  // drain all expected words, then tell the checker
  task automatic finish_test(input int num);
    while (pending != 0 || m_tvalid) next_cycle();
    repeat (2) next_cycle();
    test_num  = num;
    test_done = 1'b1;
    next_cycle();
    test_done = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int gap;
    seed       = 32'h7f3e_13bc;
    rst_n      = 1'b0;
    s_tvalid   = 1'b0;
    s_tdata    = '0;
    m_tready   = 1'b1;
    rdy_random = 1'b0;
    test_done  = 1'b0;
    all_done   = 1'b0;
    test_num   = 0;
    tb_errs    = 0;

    // reset, sweep, then silence on the output
    apply_reset();
    wait_ready_after_sweep();
    repeat (IDLE_CYCLES) next_cycle();
    finish_test(1);

    // impulse then zeros, patterns come out h[0] first
    apply_reset();
    send_beat(const_word(1));
    repeat (IMPULSE_BEATS - 1) send_beat(const_word(0));
    finish_test(2);

    // full rate stream
    apply_reset();
    repeat (RANDOM_BEATS) send_beat(random_word());
    finish_test(3);

    // output back-pressure
    apply_reset();
    rdy_random = 1'b1;
    repeat (RANDOM_BEATS) send_beat(random_word());
    finish_test(4);
    rdy_random = 1'b0;

    // input gaps with junk data on the bus
    apply_reset();
    repeat (RANDOM_BEATS) begin
      send_beat(random_word());
      gap     = $random(seed) & 3;
      s_tdata = random_word();
      repeat (gap) next_cycle();
    end
    finish_test(5);

    // range ends
    apply_reset();
    repeat (EXTREME_BEATS) send_beat(extreme_word());
    finish_test(6);

    all_done = 1'b1;
    next_cycle();
    all_done = 1'b0;
    next_cycle();
    if (total_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // watchdog
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("run timed out after %0d cycles without finishing all tests",
             WATCHDOG_CYCLES);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
+incdir+rtl
rtl/corr_pkg.sv
rtl/corr_ram_blk.sv
rtl/corr_ctrl.sv
rtl/corr_tap_chain.sv
rtl/corr_out_stage.sv
rtl/bit_corr_top.sv
test/corr_checker.sv
test/tb_bit_corr.sv

/* run_sim.sh */
#!/bin/sh
# build the bit correlator testbench with Verilator, run it and scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
  --top-module tb_bit_corr \
  -f files.f \
  -Mdir obj_dir -o sim_bit_corr

./obj_dir/sim_bit_corr > sim.log 2>&1
cat sim.log

if grep -qF "*** TEST FAILED ***" sim.log; then
  echo "simulation reported a failure, see sim.log"
  exit 1
fi
if ! grep -qF "*** TEST PASSED ***" sim.log; then
  echo "simulation ended without a pass line, see sim.log"
  exit 1
fi
echo "simulation clean"
